// ==== tb.f ====
axiAhbPkg.sv
beatBuffer.sv
axiWriteSlave.sv
axiReadSlave.sv
ahbSequencer.sv
axiToAhbBridge.sv
tbAhbMemory.sv
tbBridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tbBridge -f tb.f -o simBridge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simBridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tbBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbBridge;
    import axiAhbPkg::*;

    localparam int Timeout = 2000;

    typedef struct packed
    {
        logic [IdWidth-1:0]   id;
        logic [DataWidth-1:0] data;
        logic                 err;
        logic                 last;
    } rExp_t;

    typedef struct packed
    {
        logic [IdWidth-1:0] id;
        axiResp_e           resp;
    } bExp_t;

    logic ACLK;
    logic rst;
    logic awValid, awReady, wValid, wReady, wLast, bValid, bReady;
    logic arValid, arReady, rValid, rReady, rLast;
    logic [IdWidth-1:0] awId, bId, arId, rId;
    logic [AddrWidth-1:0] awAddr, arAddr, hAddr;
    logic [BeatIdxWidth-1:0] awLen, arLen;
    axiSize_e awSize, arSize;
    logic [DataWidth-1:0] wData, rData, hWData, hRData;
    axiResp_e bResp, rResp;
    logic hWrite, hReady, hResp;
    logic [2:0] hSize;
    ahbTrans_e hTrans;

    int        seed;
    logic [7:0] shadow [1024];
    rExp_t     rExpQ[$];
    bExp_t     bExpQ[$];
    rExp_t     rHead;
    bExp_t     bHead;
    int        rBurstDone;
    int        bDone;

    axiToAhbBridge DUT (.*);

    tbAhbMemory uMemory (.*);

    initial
    begin
        ACLK = 1'b0;
        forever
        begin
            #50 ACLK = ~ACLK;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [7:0] fillByte(input int a);
        return 8'(a * 7) ^ 8'(a >> 8);
    endfunction

    // Word at the address with lane bits cleared and the error region flagged
    function automatic readBeat_t expectedBeat(input logic [31:0] addr);
        logic [9:0]  base;
        logic [31:0] word;
        base = {addr[9:2], 2'b00};
        word = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        return '{data: word, err: (addr[31:28] == 4'hF)};
    endfunction

    function automatic void shadowWrite(input logic [31:0] addr, input axiSize_e size,
                                        input logic [31:0] data);
        int lane;
        if (addr[31:28] != 4'hF)
        begin
            for (int i = 0; i < (1 << size); i++)
            begin
                lane = int'(addr[1:0]) + i;
                shadow[{addr[9:2], 2'(lane)}] = data[8*lane +: 8];
            end
        end
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            stopRun($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bursts
    ////////////////////////////////////////////////////////////////////////////
    task automatic writeBurst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [3:0] len, input axiSize_e size);
        logic [31:0] beatData [16];
        int          target;
        int          cnt;
        for (int k = 0; k <= int'(len); k++)
        begin
            beatData[k] = $random(seed);
        end
        bExpQ.push_back('{id: id, resp: (addr[31:28] == 4'hF) ? SLVERR : OKAY});
        target = bDone + 1;
        @(posedge ACLK);
        awValid <= 1'b1;
        awId    <= id;
        awAddr  <= addr;
        awLen   <= len;
        awSize  <= size;
        cnt = 0;
        do
        begin
            @(posedge ACLK);
            cnt++;
            if (cnt > Timeout)
                stopRun("Timed out waiting for the write address to be accepted");
        end
        while (!awReady);
        awValid <= 1'b0;
        for (int k = 0; k <= int'(len); k++)
        begin
            wValid <= 1'b1;
            wData  <= beatData[k];
            wLast  <= (k == int'(len));
            cnt = 0;
            do
            begin
                @(posedge ACLK);
                cnt++;
                if (cnt > Timeout)
                    stopRun("Timed out waiting for a write data beat to be accepted");
            end
            while (!wReady);
        end
        wValid <= 1'b0;
        wLast  <= 1'b0;
        cnt = 0;
        while (bDone < target)
        begin
            @(posedge ACLK);
            cnt++;
            if (cnt > Timeout)
                stopRun("Timed out waiting for the write response");
        end
        for (int k = 0; k <= int'(len); k++)
        begin
            shadowWrite(addr + (32'(k) << size), size, beatData[k]);
        end
    endtask

    task automatic readBurst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [3:0] len, input axiSize_e size);
        readBeat_t beat;
        int        target;
        int        cnt;
        for (int k = 0; k <= int'(len); k++)
        begin
            beat = expectedBeat(addr + (32'(k) << size));
            rExpQ.push_back('{id: id, data: beat.data, err: beat.err, last: (k == int'(len))});
        end
        target = rBurstDone + 1;
        @(posedge ACLK);
        arValid <= 1'b1;
        arId    <= id;
        arAddr  <= addr;
        arLen   <= len;
        arSize  <= size;
        cnt = 0;
        do
        begin
            @(posedge ACLK);
            cnt++;
            if (cnt > Timeout)
                stopRun("Timed out waiting for the read address to be accepted");
        end
        while (!arReady);
        arValid <= 1'b0;
        cnt = 0;
        while (rBurstDone < target)
        begin
            @(posedge ACLK);
            cnt++;
            if (cnt > Timeout)
                stopRun("Timed out waiting for the last read beat");
        end
    endtask

    // Random back-pressure on both response channels
    always @(posedge ACLK)
    begin
        if (rst)
        begin
            bReady <= 1'b0;
            rReady <= 1'b0;
        end
        else
        begin
            bReady <= ({$random(seed)} % 3) != 0;
            rReady <= ({$random(seed)} % 3) != 0;
        end
    end

    // Compare every handshaked R beat and B response
    always @(posedge ACLK)
    begin
        if (!rst && rValid && rReady)
        begin
            if (rExpQ.size() == 0)
                stopRun("A read beat arrived with no read outstanding");
            rHead = rExpQ.pop_front();
            checkValue("rId", 32'(rId), 32'(rHead.id));
            if (!rHead.err)
                checkValue("rData", rData, rHead.data);
            checkValue("rResp", 32'(rResp), 32'(rHead.err ? SLVERR : OKAY));
            checkValue("rLast", 32'(rLast), 32'(rHead.last));
            if (rLast)
                rBurstDone++;
        end
        if (!rst && bValid && bReady)
        begin
            if (bExpQ.size() == 0)
                stopRun("A write response arrived with no write outstanding");
            bHead = bExpQ.pop_front();
            checkValue("bId", 32'(bId), 32'(bHead.id));
            checkValue("bResp", 32'(bResp), 32'(bHead.resp));
            bDone++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        logic [31:0] addr;
        logic [3:0]  len;
        seed = 34;
        rBurstDone = 0;
        bDone = 0;
        rst = 1'b1;
        awValid = 1'b0;
        awId = '0;
        awAddr = '0;
        awLen = '0;
        awSize = WORD;
        wValid = 1'b0;
        wData = '0;
        wLast = 1'b0;
        bReady = 1'b0;
        arValid = 1'b0;
        arId = '0;
        arAddr = '0;
        arLen = '0;
        arSize = WORD;
        rReady = 1'b0;
        for (int i = 0; i < 1024; i++)
        begin
            shadow[i] = fillByte(i);
        end
        repeat (10) @(posedge ACLK);
        rst <= 1'b0;

        // Word bursts written then read back
        for (int n = 0; n < 8; n++)
        begin
            addr = {22'd0, 4'($random(seed)), 6'd0};
            len  = 4'($random(seed));
            writeBurst(4'($random(seed)), addr, len, WORD);
            readBurst(4'($random(seed)), addr, len, WORD);
        end

        // Narrow bursts from unaligned starts
        writeBurst(4'($random(seed)), 32'h201, 4'($random(seed)), BYTE);
        readBurst(4'($random(seed)), 32'h200, 4'd4, WORD);
        writeBurst(4'($random(seed)), 32'h0A3, 4'd6, BYTE);
        readBurst(4'($random(seed)), 32'h0A0, 4'd2, WORD);
        writeBurst(4'($random(seed)), 32'h302, 4'($random(seed)), HALF);
        readBurst(4'($random(seed)), 32'h300, 4'd8, WORD);

        // Error region
        writeBurst(4'($random(seed)), 32'hF000_0040, 4'($random(seed)), WORD);
        readBurst(4'($random(seed)), 32'hF000_0040, 4'($random(seed)), WORD);

        // Write and read issued together on disjoint ranges
        for (int n = 0; n < 3; n++)
        begin
            fork
                writeBurst(4'($random(seed)), 32'h100, 4'($random(seed)), WORD);
                readBurst(4'($random(seed)), 32'h380, 4'($random(seed)), WORD);
            join
        end

        repeat (5) @(posedge ACLK);
        if (!awReady || !arReady || bValid || rValid || hTrans != IDLE)
        begin
            stopRun("The bridge did not return to idle at the end of the test");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tbAhbMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbAhbMemory (
    input  wire                             ACLK,
    input  wire                             rst,
    input  wire [axiAhbPkg::AddrWidth-1:0]  hAddr,
    input  wire                             hWrite,
    input  wire [2:0]                       hSize,
    input  wire axiAhbPkg::ahbTrans_e       hTrans,
    input  wire [axiAhbPkg::DataWidth-1:0]  hWData,
    output logic [axiAhbPkg::DataWidth-1:0] hRData,
    output logic                            hReady,
    output logic                            hResp
);
    import axiAhbPkg::*;

    logic [7:0]  mem [1024];
    int          seed;
    int          waitPick;
    int          lane;
    int          waitLeft;
    logic        active;
    logic        pWrite;
    logic        pErr;
    logic [31:0] pAddr;
    logic [2:0]  pSize;

    function automatic logic [31:0] readWord(input logic [31:0] a);
        logic [9:0] base;
        base = {a[9:2], 2'b00};
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    // Contents depend on every address bit
    initial
    begin
        seed   = 34;
        hReady = 1'b1;
        hResp  = 1'b0;
        hRData = '0;
        for (int i = 0; i < 1024; i++)
        begin
            mem[i] = 8'(i * 7) ^ 8'(i >> 8);
        end
    end

    always @(posedge ACLK)
    begin
        if (rst)
        begin
            hReady   <= 1'b1;
            hResp    <= 1'b0;
            active   <= 1'b0;
            waitLeft <= 0;
        end
        else if (hReady)
        begin
            // Data phase of the previous transfer completes here
            if (active && pWrite && !pErr)
            begin
                for (int i = 0; i < (1 << pSize); i++)
                begin
                    lane = int'(pAddr[1:0]) + i;
                    mem[{pAddr[9:2], 2'(lane)}] <= hWData[8*lane +: 8];
                end
            end
            if (hTrans == NONSEQ)
            begin
                active <= 1'b1;
                pAddr  <= hAddr;
                pWrite <= hWrite;
                pSize  <= hSize;
                pErr   <= (hAddr[31:28] == 4'hF);
                hRData <= readWord(hAddr);
                if (hAddr[31:28] == 4'hF)
                begin
                    // Two-cycle error response
                    waitLeft <= 1;
                    hReady   <= 1'b0;
                    hResp    <= 1'b1;
                end
                else
                begin
                    waitPick = int'({$random(seed)} % 4);
                    waitLeft <= waitPick;
                    hReady   <= (waitPick == 0);
                    hResp    <= 1'b0;
                end
            end
            else
            begin
                active <= 1'b0;
                hResp  <= 1'b0;
            end
        end
        else
        begin
            if (waitLeft == 1)
            begin
                hReady <= 1'b1;
            end
            waitLeft <= waitLeft - 1;
        end
    end

endmodule

`default_nettype wire

// ==== axiToAhbBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiToAhbBridge (
    input  wire                                 ACLK,
    input  wire                                 rst,
    // AXI write address, data and response
    input  wire                                 awValid,
    output logic                                awReady,
    input  wire [axiAhbPkg::IdWidth-1:0]        awId,
    input  wire [axiAhbPkg::AddrWidth-1:0]      awAddr,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0]   awLen,
    input  wire axiAhbPkg::axiSize_e            awSize,
    input  wire                                 wValid,
    output logic                                wReady,
    input  wire [axiAhbPkg::DataWidth-1:0]      wData,
    input  wire                                 wLast,
    output logic                                bValid,
    input  wire                                 bReady,
    output logic [axiAhbPkg::IdWidth-1:0]       bId,
    output axiAhbPkg::axiResp_e                 bResp,
    // AXI read address and data
    input  wire                                 arValid,
    output logic                                arReady,
    input  wire [axiAhbPkg::IdWidth-1:0]        arId,
    input  wire [axiAhbPkg::AddrWidth-1:0]      arAddr,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0]   arLen,
    input  wire axiAhbPkg::axiSize_e            arSize,
    output logic                                rValid,
    input  wire                                 rReady,
    output logic [axiAhbPkg::IdWidth-1:0]       rId,
    output logic [axiAhbPkg::DataWidth-1:0]     rData,
    output axiAhbPkg::axiResp_e                 rResp,
    output logic                                rLast,
    // AHB-Lite master
    output logic [axiAhbPkg::AddrWidth-1:0]     hAddr,
    output logic                                hWrite,
    output logic [2:0]                          hSize,
    output axiAhbPkg::ahbTrans_e                hTrans,
    output logic [axiAhbPkg::DataWidth-1:0]     hWData,
    input  wire [axiAhbPkg::DataWidth-1:0]      hRData,
    input  wire                                 hReady,
    input  wire                                 hResp
);
    import axiAhbPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////////////////////
    logic                    bufWrEn;
    logic [BeatIdxWidth-1:0] bufWrIdx;
    logic [DataWidth-1:0]    bufWrData;
    logic [BeatIdxWidth-1:0] wrBufIdx;
    logic [DataWidth-1:0]    wrBufData;
    logic                    rdBufWrEn;
    logic [BeatIdxWidth-1:0] rdBufWrIdx;
    readBeat_t               rdBufWrData;
    logic [BeatIdxWidth-1:0] bufRdIdx;
    readBeat_t               bufRdData;
    logic                    wrPend;
    burstReq_t               wrReq;
    logic                    wrDone;
    logic                    wrErr;
    logic                    rdPend;
    burstReq_t               rdReq;
    logic                    rdDone;
    logic                    rdErrAny;

    axiWriteSlave uWriteSlave (.*);

    axiReadSlave uReadSlave (.*);

    ahbSequencer uSequencer (.*);

    // W beats in, AHB write data out
    beatBuffer #(
        .Width  (DataWidth)
    ) wrBuffer (
        .ACLK   (ACLK),
        .wrEn   (bufWrEn),
        .wrIdx  (bufWrIdx),
        .wrData (bufWrData),
        .rdIdx  (wrBufIdx),
        .rdData (wrBufData)
    );

    // AHB read data with error flag, drained by the R channel
    beatBuffer #(
        .Width  ($bits(readBeat_t))
    ) rdBuffer (
        .ACLK   (ACLK),
        .wrEn   (rdBufWrEn),
        .wrIdx  (rdBufWrIdx),
        .wrData (rdBufWrData),
        .rdIdx  (bufRdIdx),
        .rdData (bufRdData)
    );

endmodule

`default_nettype wire

// ==== ahbSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbSequencer (
    input  wire                                 ACLK,
    input  wire                                 rst,
    input  wire                                 wrPend,
    input  wire axiAhbPkg::burstReq_t           wrReq,
    input  wire                                 rdPend,
    input  wire axiAhbPkg::burstReq_t           rdReq,
    input  wire [axiAhbPkg::DataWidth-1:0]      wrBufData,
    input  wire [axiAhbPkg::DataWidth-1:0]      hRData,
    input  wire                                 hReady,
    input  wire                                 hResp,
    output logic [axiAhbPkg::BeatIdxWidth-1:0]  wrBufIdx,
    output logic                                rdBufWrEn,
    output logic [axiAhbPkg::BeatIdxWidth-1:0]  rdBufWrIdx,
    output axiAhbPkg::readBeat_t                rdBufWrData,
    output logic                                wrDone,
    output logic                                wrErr,
    output logic                                rdDone,
    output logic                                rdErrAny,
    output logic [axiAhbPkg::AddrWidth-1:0]     hAddr,
    output logic                                hWrite,
    output logic [2:0]                          hSize,
    output axiAhbPkg::ahbTrans_e                hTrans,
    output logic [axiAhbPkg::DataWidth-1:0]     hWData
);
    import axiAhbPkg::*;

    typedef enum logic
    {
        seqIdle,
        seqBusy
    } seqState_e;

    seqState_e               state;
    logic                    grantWr;
    burstReq_t               req;
    logic                    addrActive;
    logic                    dataActive;
    logic [BeatIdxWidth-1:0] addrIdx;
    logic [BeatIdxWidth-1:0] dataIdx;
    logic                    errSticky;
    logic                    errNow;
    logic                    lastData;

    // Error seen so far plus the beat finishing now
    assign errNow   = errSticky || (dataActive && hResp);
    assign lastData = dataActive && hReady && (dataIdx == req.len);

    ////////////////////////////////////////////////////////////////////////////
    // Address phase of beat addrIdx
    ////////////////////////////////////////////////////////////////////////////
    assign hTrans = addrActive ? NONSEQ : IDLE;
    assign hAddr  = req.addr + (AddrWidth'(addrIdx) << req.size);
    assign hWrite = grantWr;
    assign hSize  = req.size;

    ////////////////////////////////////////////////////////////////////////////
    // Data phase of beat dataIdx
    ////////////////////////////////////////////////////////////////////////////
    assign wrBufIdx    = dataIdx;
    assign hWData      = wrBufData;
    assign rdBufWrEn   = dataActive && hReady && !grantWr;
    assign rdBufWrIdx  = dataIdx;
    assign rdBufWrData = '{data: hRData, err: hResp};

    assign wrDone   = lastData && grantWr;
    assign rdDone   = lastData && !grantWr;
    assign wrErr    = errNow;
    assign rdErrAny = errNow;

    always_ff @(posedge ACLK)
    begin
        if (rst)
        begin
            state      <= seqIdle;
            grantWr    <= 1'b0;
            addrActive <= 1'b0;
            dataActive <= 1'b0;
            errSticky  <= 1'b0;
        end
        else if (state == seqIdle)
        begin
            // Writes win when both sides are waiting
            if (wrPend || rdPend)
            begin
                state      <= seqBusy;
                grantWr    <= wrPend;
                addrActive <= 1'b1;
                errSticky  <= 1'b0;
            end
        end
        else
        begin
            errSticky <= errNow;
            if (hReady)
            begin
                dataActive <= addrActive;
                if (addrIdx == req.len)
                begin
                    addrActive <= 1'b0;
                end
            end
            if (lastData)
            begin
                state <= seqIdle;
            end
        end
    end

    // Burst fields and beat indices
    always_ff @(posedge ACLK)
    begin
        if (state == seqIdle)
        begin
            req     <= wrPend ? wrReq : rdReq;
            addrIdx <= '0;
            dataIdx <= '0;
        end
        else if (hReady)
        begin
            dataIdx <= addrIdx;
            if (addrActive && (addrIdx != req.len))
            begin
                addrIdx <= addrIdx + 1'b1;
            end
        end
    end

    assert property (@(posedge ACLK) disable iff (rst)
        state == seqIdle |-> hTrans != NONSEQ);

    // The write side must drop its request right after completion
    assert property (@(posedge ACLK) disable iff (rst)
        wrDone |=> !wrPend);

endmodule

`default_nettype wire

// ==== axiReadSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiReadSlave (
    input  wire                                 ACLK,
    input  wire                                 rst,
    input  wire                                 arValid,
    input  wire [axiAhbPkg::IdWidth-1:0]        arId,
    input  wire [axiAhbPkg::AddrWidth-1:0]      arAddr,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0]   arLen,
    input  wire axiAhbPkg::axiSize_e            arSize,
    input  wire                                 rReady,
    input  wire                                 rdDone,
    input  wire                                 rdErrAny,
    input  wire axiAhbPkg::readBeat_t           bufRdData,
    output logic                                arReady,
    output logic                                rValid,
    output logic [axiAhbPkg::IdWidth-1:0]       rId,
    output logic [axiAhbPkg::DataWidth-1:0]     rData,
    output axiAhbPkg::axiResp_e                 rResp,
    output logic                                rLast,
    output logic [axiAhbPkg::BeatIdxWidth-1:0]  bufRdIdx,
    output logic                                rdPend,
    output axiAhbPkg::burstReq_t                rdReq
);
    import axiAhbPkg::*;

    typedef enum logic [1:0]
    {
        rdIdle,
        rdAhb,
        rdStream
    } rdState_e;

    rdState_e                state;
    logic [BeatIdxWidth-1:0] beatIdx;
    logic                    errAny;

    assign arReady = (state == rdIdle);
    assign rdPend  = (state == rdAhb);
    assign rValid  = (state == rdStream);

    ////////////////////////////////////////////////////////////////////////////
    // R channel fed from the read buffer
    ////////////////////////////////////////////////////////////////////////////
    assign bufRdIdx = beatIdx;
    assign rId      = rdReq.id;
    assign rData    = bufRdData.data;
    assign rResp    = bufRdData.err ? SLVERR : OKAY;
    assign rLast    = (beatIdx == rdReq.len);

    always_ff @(posedge ACLK)
    begin
        if (rst)
        begin
            state <= rdIdle;
        end
        else
        begin
            case (state)
                rdIdle:
                    if (arValid)
                    begin
                        state <= rdAhb;
                    end
                rdAhb:
                    if (rdDone)
                    begin
                        state <= rdStream;
                    end
                rdStream:
                    if (rReady && rLast)
                    begin
                        state <= rdIdle;
                    end
                default:
                    state <= rdIdle;
            endcase
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (arValid && arReady)
        begin
            rdReq <= '{id: arId, addr: arAddr, len: arLen, size: arSize};
        end
        // Stream restarts at entry 0 once the AHB side is finished
        if (rdDone && rdPend)
        begin
            beatIdx <= '0;
            errAny  <= rdErrAny;
        end
        else if (rValid && rReady)
        begin
            beatIdx <= beatIdx + 1'b1;
        end
    end

    assert property (@(posedge ACLK) disable iff (rst)
        rValid && !rReady |=> $stable(rData) && $stable(rLast));

    // A failed beat must have been flagged by the sequencer
    assert property (@(posedge ACLK) disable iff (rst)
        rValid && bufRdData.err |-> errAny);

endmodule

`default_nettype wire

// ==== axiWriteSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiWriteSlave (
    input  wire                                 ACLK,
    input  wire                                 rst,
    input  wire                                 awValid,
    input  wire [axiAhbPkg::IdWidth-1:0]        awId,
    input  wire [axiAhbPkg::AddrWidth-1:0]      awAddr,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0]   awLen,
    input  wire axiAhbPkg::axiSize_e            awSize,
    input  wire                                 wValid,
    input  wire [axiAhbPkg::DataWidth-1:0]      wData,
    input  wire                                 wLast,
    input  wire                                 bReady,
    input  wire                                 wrDone,
    input  wire                                 wrErr,
    output logic                                awReady,
    output logic                                wReady,
    output logic                                bValid,
    output logic [axiAhbPkg::IdWidth-1:0]       bId,
    output axiAhbPkg::axiResp_e                 bResp,
    output logic                                bufWrEn,
    output logic [axiAhbPkg::BeatIdxWidth-1:0]  bufWrIdx,
    output logic [axiAhbPkg::DataWidth-1:0]     bufWrData,
    output logic                                wrPend,
    output axiAhbPkg::burstReq_t                wrReq
);
    import axiAhbPkg::*;

    typedef enum logic [1:0]
    {
        wrIdle,
        wrData,
        wrAhb,
        wrResp
    } wrState_e;

    wrState_e                state;
    logic [BeatIdxWidth-1:0] beatCnt;

    ////////////////////////////////////////////////////////////////////////////
    // Channel levels straight from the state
    ////////////////////////////////////////////////////////////////////////////
    assign awReady = (state == wrIdle);
    assign wReady  = (state == wrData);
    assign wrPend  = (state == wrAhb);
    assign bValid  = (state == wrResp);
    assign bId     = wrReq.id;

    // Each accepted W beat lands at entry beatCnt
    assign bufWrEn   = wValid && wReady;
    assign bufWrIdx  = beatCnt;
    assign bufWrData = wData;

    always_ff @(posedge ACLK)
    begin
        if (rst)
        begin
            state <= wrIdle;
        end
        else
        begin
            case (state)
                wrIdle:
                    if (awValid)
                    begin
                        state <= wrData;
                    end
                wrData:
                    if (wValid && wLast)
                    begin
                        state <= wrAhb;
                    end
                wrAhb:
                    if (wrDone)
                    begin
                        state <= wrResp;
                    end
                wrResp:
                    if (bReady)
                    begin
                        state <= wrIdle;
                    end
                default:
                    state <= wrIdle;
            endcase
        end
    end

    // Burst fields, beat counter and response code
    always_ff @(posedge ACLK)
    begin
        if (awValid && awReady)
        begin
            wrReq   <= '{id: awId, addr: awAddr, len: awLen, size: awSize};
            beatCnt <= '0;
        end
        else if (bufWrEn)
        begin
            beatCnt <= beatCnt + 1'b1;
        end
        if (wrDone && wrPend)
        begin
            bResp <= wrErr ? SLVERR : OKAY;
        end
    end

    // Response must wait for the master
    assert property (@(posedge ACLK) disable iff (rst)
        bValid && !bReady |=> bValid && $stable(bResp));

endmodule

`default_nettype wire

// ==== beatBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module beatBuffer #(
    parameter int Width = 32
) (
    input  wire                               ACLK,
    input  wire                               wrEn,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0] wrIdx,
    input  wire [Width-1:0]                   wrData,
    input  wire [axiAhbPkg::BeatIdxWidth-1:0] rdIdx,
    output logic [Width-1:0]                  rdData
);
    import axiAhbPkg::*;

    // One entry per beat of the longest burst
    logic [Width-1:0] mem [MaxBeats];

    always_ff @(posedge ACLK)
    begin
        if (wrEn)
        begin
            mem[wrIdx] <= wrData;
        end
    end

    // Combinational read so the consumer sees the beat in the same cycle
    assign rdData = mem[rdIdx];

endmodule

`default_nettype wire

// ==== axiAhbPkg.sv ====
`default_nettype none

package axiAhbPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and buffer dimensions
    ////////////////////////////////////////////////////////////////////////////
    localparam int AddrWidth    = 32;
    localparam int DataWidth    = 32;
    localparam int IdWidth      = 4;
    localparam int MaxBeats     = 16;
    localparam int BeatIdxWidth = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0]
    {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axiResp_e;

    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,
        NONSEQ = 2'd2
    } ahbTrans_e;

    // Same values as AHB HSIZE
    typedef enum logic [2:0]
    {
        BYTE = 3'd0,
        HALF = 3'd1,
        WORD = 3'd2
    } axiSize_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////
    // One accepted AXI burst, len is beats minus one
    typedef struct packed
    {
        logic [IdWidth-1:0]      id;
        logic [AddrWidth-1:0]    addr;
        logic [BeatIdxWidth-1:0] len;
        axiSize_e                size;
    } burstReq_t;

    // Read beat as stored for the R channel
    typedef struct packed
    {
        logic [DataWidth-1:0] data;
        logic                 err;
    } readBeat_t;

endpackage

`default_nettype wire
